/* verilog/xvid_macros.svh */
// fixed 640x480 raster geometry, register numbers and reset values; include where needed
`ifndef XVID_MACROS_SVH
`define XVID_MACROS_SVH

// horizontal geometry in pixel clocks
`define XV_VISIBLE_WIDTH    640
`define XV_OFFSCREEN_WIDTH  160                         // left of visible part
`define XV_TOTAL_WIDTH      800
`define XV_HSYNC_START      16
`define XV_HSYNC_END        112

// vertical geometry in lines
`define XV_VISIBLE_HEIGHT   480
`define XV_TOTAL_HEIGHT     525
`define XV_VSYNC_START      490
`define XV_VSYNC_END        492

`define XV_MEM_BEGIN        (`XV_OFFSCREEN_WIDTH - 64)  // prefetch ahead of visible
`define XV_MEM_END          (`XV_TOTAL_WIDTH - 8)
`define XV_FETCH_SPACING    8                           // pixels per display word

`define XR_VID_CTRL         6'h00
`define XR_SCANLINE         6'h03
`define XR_VID_LEFT         6'h04
`define XR_VID_RIGHT        6'h05
`define XR_PA_GFX_CTRL      6'h10
`define XR_PA_DISP_ADDR     6'h12
`define XR_PA_LINE_LEN      6'h13
`define XR_PA_LINE_ADDR     6'h16

`define XV_RESET_BORDER     8'h08                       // dark grey border
`define XV_RESET_LINE_LEN   (`XV_VISIBLE_WIDTH / `XV_FETCH_SPACING)

`endif

/* verilog/xvid_pkg.sv */
// shared word, counter, colour and configuration types for the video generator blocks
package xvid_pkg;

typedef logic [15:0] word_t;                // register data word
typedef logic [15:0] addr_t;                // vram word address
typedef logic [9:0]  hres_t;                // horizontal pixel count
typedef logic [9:0]  vres_t;                // vertical line count
typedef logic [7:0]  color_t;               // palette index

// VID_CTRL view of a register word
typedef struct packed {
    logic [7:0] unused;                     // reads back zero
    color_t     border_color;
} vid_ctrl_t;

// PA_GFX_CTRL view of a register word
typedef struct packed {
    color_t     colorbase;
    logic       blank;                      // playfield off, border only
    logic [6:0] reserved;                   // reads back zero
} gfx_ctrl_t;

typedef union packed {
    word_t      raw;
    vid_ctrl_t  vid;
    gfx_ctrl_t  gfx;
} reg_word_u;

typedef struct packed {
    hres_t      h_count;
    vres_t      v_count;
    logic       h_visible;                  // pixel right of offscreen area
    logic       v_visible;                  // line above bottom blank
    logic       end_of_line;
    logic       end_of_frame;
    logic       end_of_visible;             // last pixel of last visible line
} raster_t;

typedef struct packed {
    logic       blank;
    color_t     colorbase;
    color_t     border_color;
    hres_t      vid_left;                   // display window, visible pixel units
    hres_t      vid_right;                  // exclusive
    addr_t      start_addr;                 // first line address of each frame
    word_t      line_len;                   // words added per visible line
    logic       line_set;                   // one cycle strobe
    addr_t      line_set_addr;
} pf_cfg_t;

endpackage

/* verilog/video_timing.sv */
// raster counters, sync pulses and frame events; one instance feeds the register and fetch blocks
`default_nettype none
`timescale 1ns/1ps

`include "xvid_macros.svh"

module video_timing import xvid_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    output      raster_t    raster_o,       // counts and decoded flags, same cycle
    output      logic       hsync_o,
    output      logic       vsync_o,
    output      logic       dv_de_o
);

hres_t  h_count;
vres_t  v_count;
logic   h_last;                             // pixel 799
logic   v_last;                             // line 524
logic   h_visible;
logic   v_visible;

always_comb begin
    h_last      = (h_count == hres_t'(`XV_TOTAL_WIDTH - 1));
    v_last      = (v_count == vres_t'(`XV_TOTAL_HEIGHT - 1));
    h_visible   = (h_count >= hres_t'(`XV_OFFSCREEN_WIDTH));
    v_visible   = (v_count < vres_t'(`XV_VISIBLE_HEIGHT));
end

// counter pair, v steps on h wrap
always_ff @(posedge clk) begin
    if (reset_i) begin
        h_count <= '0;
        v_count <= '0;
    end else begin
        h_count <= h_last ? '0 : h_count + 1'b1;
        if (h_last) begin
            v_count <= v_last ? '0 : v_count + 1'b1;
        end
    end
end

always_comb begin
    raster_o.h_count        = h_count;
    raster_o.v_count        = v_count;
    raster_o.h_visible      = h_visible;
    raster_o.v_visible      = v_visible;
    raster_o.end_of_line    = h_last;
    raster_o.end_of_frame   = h_last & v_last;
    raster_o.end_of_visible = h_last & (v_count == vres_t'(`XV_VISIBLE_HEIGHT - 1));
end

// syncs lag the counts by one clock
always_ff @(posedge clk) begin
    if (reset_i) begin
        hsync_o <= 1'b0;
        vsync_o <= 1'b0;
        dv_de_o <= 1'b0;
    end else begin
        hsync_o <= (h_count >= hres_t'(`XV_HSYNC_START)) &&
                   (h_count < hres_t'(`XV_HSYNC_END));      // active high
        vsync_o <= (v_count >= vres_t'(`XV_VSYNC_START)) &&
                   (v_count < vres_t'(`XV_VSYNC_END));
        dv_de_o <= h_visible & v_visible;
    end
end

endmodule

`default_nettype wire

/* verilog/video_regs.sv */
// video configuration registers with host write, registered read-back and the vblank interrupt
`default_nettype none
`timescale 1ns/1ps

`include "xvid_macros.svh"

module video_regs import xvid_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       reg_wr_i,       // write strobe
    input  wire logic [5:0] reg_num_i,      // selects both write and read register
    input  wire reg_word_u  reg_data_i,
    output      word_t      reg_data_o,
    input  wire raster_t    raster_i,
    output      pf_cfg_t    pf_cfg_o,
    output      logic       intr_o          // one pulse per frame
);

color_t     border_color;
logic       blank;
color_t     colorbase;
hres_t      vid_left;
hres_t      vid_right;
addr_t      start_addr;
word_t      line_len;
logic       line_set;
addr_t      line_set_addr;
reg_word_u  rd_word;

always_ff @(posedge clk) begin
    if (reset_i) begin
        border_color    <= `XV_RESET_BORDER;
        blank           <= 1'b0;
        colorbase       <= '0;
        vid_left        <= '0;
        vid_right       <= hres_t'(`XV_VISIBLE_WIDTH);
        start_addr      <= '0;
        line_len        <= word_t'(`XV_RESET_LINE_LEN);
        line_set        <= 1'b0;
        intr_o          <= 1'b0;
    end else begin
        line_set        <= 1'b0;
        intr_o          <= raster_i.end_of_visible;
        if (reg_wr_i) begin
            case (reg_num_i)
                `XR_VID_CTRL: begin
                    border_color <= reg_data_i.vid.border_color;
                end
                `XR_VID_LEFT:       vid_left    <= reg_data_i.raw[9:0];
                `XR_VID_RIGHT:      vid_right   <= reg_data_i.raw[9:0];
                `XR_PA_GFX_CTRL: begin
                    colorbase   <= reg_data_i.gfx.colorbase;
                    blank       <= reg_data_i.gfx.blank;
                end
                `XR_PA_DISP_ADDR:   start_addr  <= reg_data_i.raw;
                `XR_PA_LINE_LEN:    line_len    <= reg_data_i.raw;
                `XR_PA_LINE_ADDR:   line_set    <= 1'b1;    // fetch picks up next line
                default: begin
                end
            endcase
        end
    end
end

// line address captured alongside its strobe
always_ff @(posedge clk) begin
    if (reg_wr_i && reg_num_i == `XR_PA_LINE_ADDR) begin
        line_set_addr <= reg_data_i.raw;
    end
end

always_comb begin
    rd_word.raw = '0;
    case (reg_num_i)
        `XR_VID_CTRL: begin
            rd_word.vid.border_color = border_color;
        end
        `XR_SCANLINE:       rd_word.raw = word_t'(raster_i.v_count);
        `XR_VID_LEFT:       rd_word.raw = word_t'(vid_left);
        `XR_VID_RIGHT:      rd_word.raw = word_t'(vid_right);
        `XR_PA_GFX_CTRL: begin
            rd_word.gfx.colorbase   = colorbase;
            rd_word.gfx.blank       = blank;
        end
        `XR_PA_DISP_ADDR:   rd_word.raw = start_addr;
        `XR_PA_LINE_LEN:    rd_word.raw = line_len;
        `XR_PA_LINE_ADDR:   rd_word.raw = '0;           // write only
        default: begin
        end
    endcase
end

always_ff @(posedge clk) begin
    reg_data_o <= rd_word.raw;
end

always_comb begin
    pf_cfg_o.blank          = blank;
    pf_cfg_o.colorbase      = colorbase;
    pf_cfg_o.border_color   = border_color;
    pf_cfg_o.vid_left       = vid_left;
    pf_cfg_o.vid_right      = vid_right;
    pf_cfg_o.start_addr     = start_addr;
    pf_cfg_o.line_len       = line_len;
    pf_cfg_o.line_set       = line_set;
    pf_cfg_o.line_set_addr  = line_set_addr;
end

endmodule

`default_nettype wire

/* verilog/line_fetch.sv */
// playfield fetch window, display address walk and border/window colour for each scanline
`default_nettype none
`timescale 1ns/1ps

`include "xvid_macros.svh"

module line_fetch import xvid_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire raster_t    raster_i,
    input  wire pf_cfg_t    pf_cfg_i,
    output      logic       vram_sel_o,     // read strobe, no ack
    output      addr_t      vram_addr_o,
    output      color_t     color_index_o,
    output      logic       h_blank_o,
    output      logic       v_blank_o
);

logic   mem_fetch;                          // inside fetch window
logic   fetch_start;
logic   fetch_end;
logic   fetch_now;
addr_t  line_addr;                          // first word of current line
addr_t  fetch_addr;
hres_t  h_pos;                              // visible pixel position
logic   in_window;

always_comb begin
    fetch_start = (raster_i.h_count == hres_t'(`XV_MEM_BEGIN));
    fetch_end   = (raster_i.h_count == hres_t'(`XV_MEM_END));
    fetch_now   = mem_fetch && !pf_cfg_i.blank &&
                  ((raster_i.h_count % hres_t'(`XV_FETCH_SPACING)) == '0);
    h_pos       = raster_i.h_count - hres_t'(`XV_OFFSCREEN_WIDTH);
    in_window   = (h_pos >= pf_cfg_i.vid_left) && (h_pos < pf_cfg_i.vid_right);
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        mem_fetch   <= 1'b0;
        vram_sel_o  <= 1'b0;
        line_addr   <= '0;
    end else begin
        mem_fetch   <= (!mem_fetch ? fetch_start : !fetch_end) && raster_i.v_visible;
        vram_sel_o  <= fetch_now;
        if (pf_cfg_i.line_set) begin
            line_addr <= pf_cfg_i.line_set_addr;            // host override wins
        end else if (raster_i.end_of_frame) begin
            line_addr <= pf_cfg_i.start_addr;
        end else if (raster_i.end_of_line && raster_i.v_visible) begin
            line_addr <= line_addr + pf_cfg_i.line_len;
        end
    end
end

// address walk within the line
always_ff @(posedge clk) begin
    if (fetch_start) begin
        fetch_addr <= line_addr;
    end else if (fetch_now) begin
        fetch_addr <= fetch_addr + 1'b1;
    end
    if (fetch_now) begin
        vram_addr_o <= fetch_addr;
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        color_index_o   <= '0;
        h_blank_o       <= 1'b1;
        v_blank_o       <= 1'b1;
    end else begin
        h_blank_o       <= ~raster_i.h_visible;
        v_blank_o       <= ~raster_i.v_visible;
        if (raster_i.h_visible && raster_i.v_visible) begin
            color_index_o <= (in_window && !pf_cfg_i.blank) ? pf_cfg_i.colorbase
                                                           : pf_cfg_i.border_color;
        end else begin
            color_index_o <= '0;                            // black in blanking
        end
    end
end

endmodule

`default_nettype wire

/* verilog/video_gen.sv */
// top level of the video front end, joining raster timing, config registers and line fetch
`default_nettype none
`timescale 1ns/1ps

module video_gen import xvid_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       vgen_reg_wr_en_i,   // host register write strobe
    input  wire logic [5:0] vgen_reg_num_i,
    input  wire word_t      vgen_reg_data_i,
    output      word_t      vgen_reg_data_o,
    output      logic       video_intr_o,       // end of visible area
    output      logic       vram_sel_o,
    output      addr_t      vram_addr_o,
    output      color_t     color_index_o,
    output      logic       h_blank_o,
    output      logic       v_blank_o,
    output      logic       hsync_o,
    output      logic       vsync_o,
    output      logic       dv_de_o
);

raster_t    raster;
pf_cfg_t    pf_cfg;

video_timing video_timing (
    .clk        (clk),
    .reset_i    (reset_i),
    .raster_o   (raster),
    .hsync_o    (hsync_o),
    .vsync_o    (vsync_o),
    .dv_de_o    (dv_de_o)
);

video_regs video_regs (
    .clk        (clk),
    .reset_i    (reset_i),
    .reg_wr_i   (vgen_reg_wr_en_i),
    .reg_num_i  (vgen_reg_num_i),
    .reg_data_i (vgen_reg_data_i),
    .reg_data_o (vgen_reg_data_o),
    .raster_i   (raster),
    .pf_cfg_o   (pf_cfg),
    .intr_o     (video_intr_o)
);

line_fetch line_fetch (
    .clk            (clk),
    .reset_i        (reset_i),
    .raster_i       (raster),
    .pf_cfg_i       (pf_cfg),
    .vram_sel_o     (vram_sel_o),
    .vram_addr_o    (vram_addr_o),
    .color_index_o  (color_index_o),
    .h_blank_o      (h_blank_o),
    .v_blank_o      (v_blank_o)
);

endmodule

`default_nettype wire

/* bench/video_gen_tb.sv */
// self-checking testbench for video_gen; compile with xvid.f and run video_gen_tb as top
`timescale 1ns/1ps

`include "xvid_macros.svh"

module video_gen_tb import xvid_pkg::*; ();

localparam int CLK_PERIOD  = 20;
localparam int FRAME_CYC   = `XV_TOTAL_WIDTH * `XV_TOTAL_HEIGHT;
localparam int FETCH_WORDS = (`XV_MEM_END - `XV_MEM_BEGIN) / `XV_FETCH_SPACING;
localparam int INTR_LEAD   = (`XV_VSYNC_START - `XV_VISIBLE_HEIGHT) * `XV_TOTAL_WIDTH + 1;
localparam int SET_LINE    = 3;             // line that gets the PA_LINE_ADDR override

logic       clk;
logic       reset_i;
logic       vgen_reg_wr_en_i;
logic [5:0] vgen_reg_num_i;
word_t      vgen_reg_data_i;
word_t      vgen_reg_data_o;
logic       video_intr_o;
logic       vram_sel_o;
addr_t      vram_addr_o;
color_t     color_index_o;
logic       h_blank_o;
logic       v_blank_o;
logic       hsync_o;
logic       vsync_o;
logic       dv_de_o;

// host-side copy of the register file
color_t     sh_border   = `XV_RESET_BORDER;
color_t     sh_cb       = '0;
logic       sh_blank    = 1'b0;
hres_t      sh_left     = '0;
hres_t      sh_right    = `XV_VISIBLE_WIDTH;
addr_t      sh_disp     = '0;
word_t      sh_len      = `XV_RESET_LINE_LEN;

int         errors      = 0;
integer     seed        = 32'h6303_f870;
int         cyc, hs_last, vs_last, intr_last, intr_cnt, de_run, vs_checks;
int         tb_line;                        // line count from sync edges
int         cb_cnt, bad_cnt;
int         hvis_cnt;                       // h_blank_o low samples this line
int         vvis_cnt;                       // v_blank_o low samples this frame
int         de_lines;                       // display enable runs this frame
logic       hs_q, vs_q, intr_q, de_q, hs_seen, vs_seen;
logic       rec_on      = 1'b0;
int         fl[$];                          // line of each recorded fetch
addr_t      fa[$];
int         cb_q[$];
int         bad_q[$];
addr_t      set_a;
int         n;
logic [5:0] listed [8] = '{`XR_VID_CTRL, `XR_SCANLINE, `XR_VID_LEFT, `XR_VID_RIGHT,
                           `XR_PA_GFX_CTRL, `XR_PA_DISP_ADDR, `XR_PA_LINE_LEN,
                           `XR_PA_LINE_ADDR};

video_gen dut (.*);

initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
end

initial begin
    #(4 * FRAME_CYC * CLK_PERIOD);
    $display("timeout: run did not finish within four frames");
    $display("*** FAILED ***");
    $finish;
end

task automatic check(input string name, input logic [31:0] exp_val, input logic [31:0] act_val);
    if (exp_val !== act_val) begin
        errors++;
        $display("ERR %s expected %0h actual %0h", name, exp_val, act_val);
    end
endtask

// expected read-back from the register rules
function automatic word_t ref_reg_read(input logic [5:0] num, input int line);
    case (num)
        `XR_VID_CTRL:     ref_reg_read = {8'h00, sh_border};
        `XR_SCANLINE:     ref_reg_read = word_t'(line);
        `XR_VID_LEFT:     ref_reg_read = {6'h00, sh_left};
        `XR_VID_RIGHT:    ref_reg_read = {6'h00, sh_right};
        `XR_PA_GFX_CTRL:  ref_reg_read = {sh_cb, sh_blank, 7'h00};
        `XR_PA_DISP_ADDR: ref_reg_read = sh_disp;
        `XR_PA_LINE_LEN:  ref_reg_read = sh_len;
        default:          ref_reg_read = 16'h0000;  // LINE_ADDR and unlisted
    endcase
endfunction

function automatic addr_t fetch_base(input int line);
    if (line < SET_LINE) begin
        fetch_base = sh_disp + addr_t'(line) * sh_len;
    end else begin
        fetch_base = set_a + addr_t'(line - SET_LINE) * sh_len;
    end
endfunction

task automatic write_reg(input logic [5:0] num, input word_t data);
    case (num)
        `XR_VID_CTRL:     sh_border = data[7:0];
        `XR_VID_LEFT:     sh_left = data[9:0];
        `XR_VID_RIGHT:    sh_right = data[9:0];
        `XR_PA_GFX_CTRL: begin
            sh_cb = data[15:8];
            sh_blank = data[7];
        end
        `XR_PA_DISP_ADDR: sh_disp = data;
        `XR_PA_LINE_LEN:  sh_len = data;
        default: begin
        end
    endcase
    @(posedge clk);
    vgen_reg_wr_en_i <= 1'b1;
    vgen_reg_num_i   <= num;
    vgen_reg_data_i  <= data;
    @(posedge clk);
    vgen_reg_wr_en_i <= 1'b0;
endtask

// read just after an hsync rise so the scanline count is settled
task automatic read_and_check(input logic [5:0] num);
    word_t val;
    @(posedge hsync_o);
    @(posedge clk);
    vgen_reg_num_i <= num;
    @(posedge clk);
    @(negedge clk);
    val = vgen_reg_data_o;
    check($sformatf("read reg %02h", num), ref_reg_read(num, tb_line), val);
endtask

// raster, blanking, interrupt, fetch and colour monitor
always @(posedge clk) begin
    if (reset_i) begin
        {cyc, intr_cnt, de_run, vs_checks, cb_cnt, bad_cnt} = '0;
        {hvis_cnt, vvis_cnt, de_lines} = '0;
        {hs_q, vs_q, intr_q, de_q, hs_seen, vs_seen} = '0;
        tb_line = `XV_TOTAL_HEIGHT - 1;
    end else begin
        cyc++;
        if (hsync_o && !hs_q) begin
            if (hs_seen) begin
                check("hsync period", `XV_TOTAL_WIDTH, cyc - hs_last);
                check("h_blank low per line", `XV_VISIBLE_WIDTH, hvis_cnt);
            end
            hs_seen = 1'b1;
            hs_last = cyc;
            if (rec_on) begin
                cb_q.push_back(cb_cnt);
                bad_q.push_back(bad_cnt);
            end
            cb_cnt = 0;
            bad_cnt = 0;
            hvis_cnt = 0;
            tb_line = (tb_line + 1) % `XV_TOTAL_HEIGHT;
        end
        if (vsync_o && !vs_q) begin
            if (vs_seen) begin
                check("vsync period", FRAME_CYC, cyc - vs_last);
                check("v_blank low per frame", `XV_VISIBLE_HEIGHT * `XV_TOTAL_WIDTH,
                      vvis_cnt);
                check("display enable lines per frame", `XV_VISIBLE_HEIGHT, de_lines);
                vs_checks++;
            end
            check("interrupts per frame", 1, intr_cnt);
            check("interrupt lead", INTR_LEAD, cyc - intr_last);
            vs_seen = 1'b1;
            vs_last = cyc;
            intr_cnt = 0;
            vvis_cnt = 0;
            de_lines = 0;
            tb_line = `XV_VSYNC_START - 1;  // next hsync rise is the vsync line
        end
        if (video_intr_o && intr_q) begin
            errors++;
            $display("interrupt pulse lasted longer than one cycle");
        end else if (video_intr_o) begin
            intr_cnt++;
            intr_last = cyc;
        end
        if (dv_de_o) de_run++;
        if (!dv_de_o && de_q) begin
            check("display enable length", `XV_VISIBLE_WIDTH, de_run);
            de_run = 0;
            de_lines++;
        end
        if (!h_blank_o) hvis_cnt++;
        if (!v_blank_o) vvis_cnt++;
        if (vram_sel_o && rec_on) begin
            fl.push_back(tb_line);
            fa.push_back(vram_addr_o);
        end
        if (!h_blank_o && !v_blank_o) begin
            if (color_index_o == sh_cb) cb_cnt++;
            else if (color_index_o != sh_border) bad_cnt++;
        end
        hs_q = hsync_o;
        vs_q = vsync_o;
        intr_q = video_intr_o;
        de_q = dv_de_o;
    end
end

initial begin
    reset_i = 1'b1;
    vgen_reg_wr_en_i = 1'b0;
    vgen_reg_num_i = '0;
    vgen_reg_data_i = '0;
    repeat (2) @(posedge clk);
    reset_i <= 1'b0;

    foreach (listed[i]) read_and_check(listed[i]);
    for (int r = 0; r < 64; r++) begin
        write_reg(6'(r), word_t'($random(seed)));
        read_and_check(6'(r));
    end

    // fetch walk and window colour over lines 0 to 5 of the next frame
    set_a = $random(seed);
    write_reg(`XR_PA_DISP_ADDR, word_t'($random(seed)));
    write_reg(`XR_PA_LINE_LEN, {8'h00, 8'($random(seed))});
    write_reg(`XR_VID_LEFT, word_t'({$random(seed)} % 320));
    write_reg(`XR_VID_RIGHT, word_t'(320 + {$random(seed)} % 321));
    write_reg(`XR_PA_GFX_CTRL, {8'($random(seed)), 8'h00});
    write_reg(`XR_VID_CTRL, {8'h00, sh_cb ^ 8'h5a});   // border differs from base
    @(posedge vsync_o);
    wait (tb_line == 0);
    rec_on = 1'b1;
    wait (tb_line == SET_LINE);
    write_reg(`XR_PA_LINE_ADDR, set_a);
    wait (tb_line == 6);
    rec_on = 1'b0;
    for (int ln = 0; ln < 6; ln++) begin
        n = 0;
        foreach (fl[k]) begin
            if (fl[k] == ln) begin
                check($sformatf("fetch addr line %0d", ln), addr_t'(fetch_base(ln) + n), fa[k]);
                n++;
            end
        end
        check($sformatf("fetch count line %0d", ln), FETCH_WORDS, n);
    end
    check("colour lines recorded", 6, cb_q.size());
    foreach (cb_q[k]) begin
        check($sformatf("window pixels line %0d", k), sh_right - sh_left, cb_q[k]);
        check($sformatf("stray colours line %0d", k), 0, bad_q[k]);
    end

    // blank set: no strobes, border only
    write_reg(`XR_PA_GFX_CTRL, {sh_cb, 8'h80});
    wait (tb_line == 8);
    fl.delete();
    cb_q.delete();
    bad_q.delete();
    rec_on = 1'b1;
    wait (tb_line == 11);
    rec_on = 1'b0;
    check("strobes while blanked", 0, fl.size());
    check("blanked lines recorded", 3, cb_q.size());
    foreach (cb_q[k]) begin
        check($sformatf("blanked window pixels %0d", k), 0, cb_q[k]);
        check($sformatf("blanked stray colours %0d", k), 0, bad_q[k]);
    end

    @(posedge vsync_o);
    repeat (2) @(posedge clk);
    if (vs_checks == 0) begin
        errors++;
        $display("no complete frame was measured between vsync pulses");
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
        $display("*** PASSED ***");
    end else begin
        $display("*** FAILED ***");
    end
    $finish;
end

endmodule

/* xvid.f */
+incdir+verilog
verilog/xvid_pkg.sv
verilog/video_timing.sv
verilog/video_regs.sv
verilog/line_fetch.sv
verilog/video_gen.sv
bench/video_gen_tb.sv
